// ==== mem_stage.f ====
+incdir+include
verilog/mem_pkg.sv
verilog/mem_stage_reg.sv
verilog/load_aligner.sv
verilog/mem_result_merge.sv
verilog/mem_stage.sv
verif/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the mem stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module mem_stage_tb -f mem_stage.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vmem_stage_tb)
status=$?
echo "$out"

if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '^>>> PASS$'; then
    exit 0
fi

echo "pass message not found in simulation output"
exit 1

// ==== verif/mem_stage_tb.sv ====
`timescale 1ns/1ns

module mem_stage_tb
    import mem_pkg::*;
();

    localparam int NUM_INSTR   = 600;
    localparam int CYCLE_LIMIT = NUM_INSTR * 8 + 100;

    logic     clk;
    logic     resetn;
    logic     ex_valid, ex_gr_we, ex_res_from_mem, ex_csr_we, ex_csr_re, ex_ertn, ex_syscall;
    mem_op_e  ex_mem_op;
    logic [1:0] ex_addr_low2;
    reg_idx_t ex_dest;
    csr_num_t ex_csr_num;
    word_t    ex_pc, ex_inst, ex_alu_result, ex_csr_wmask, ex_csr_wvalue;
    logic     wb_allowin, wb_ex, ertn_flush;
    word_t    data_sram_rdata;

    logic     mem_allowin, mem_wb_valid, mem_ex;
    logic     wb_gr_we, wb_csr_we, wb_csr_re, wb_ertn, wb_syscall;
    word_t    wb_pc, wb_inst, wb_result, wb_csr_wmask, wb_csr_wvalue;
    reg_idx_t wb_dest, fwd_dest;
    csr_num_t wb_csr_num, fwd_csr_num;
    logic     fwd_valid, fwd_is_csr;
    word_t    fwd_result;

    // model of the single held instruction
    logic     pend, p_gr_we, p_res_from_mem, p_csr_we, p_csr_re, p_ertn, p_syscall;
    mem_op_e  p_op;
    logic [1:0] p_a;
    reg_idx_t p_dest;
    csr_num_t p_csr_num;
    word_t    p_pc, p_inst, p_alu, p_csr_wmask, p_csr_wvalue, p_sram;

    integer   seed;
    int       accepted, retired, dropped;
    int       cycles = 0;
    logic     took_new;

    mem_stage dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t got, input reg_idx_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_csr(input string name, input csr_num_t got, input csr_num_t exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    function automatic word_t expected_load(input mem_op_e op, input logic [1:0] a,
                                            input word_t w);
        word_t byte_shift;
        word_t half_shift;
        word_t res;
        byte_shift = w >> (8 * a);
        half_shift = w >> (16 * a[1]);
        case (op)
            ld_b:    res = {{24{byte_shift[7]}}, byte_shift[7:0]};
            ld_bu:   res = {24'd0, byte_shift[7:0]};
            ld_h:    res = {{16{half_shift[15]}}, half_shift[15:0]};
            ld_hu:   res = {16'd0, half_shift[15:0]};
            default: res = w;
        endcase
        return res;
    endfunction

    task automatic new_offer();
        logic [31:0] r;
        int unsigned pick;
        pick = $unsigned($random(seed)) % 5;
        case (pick)
            0: ex_mem_op <= ld_w;
            1: ex_mem_op <= ld_h;
            2: ex_mem_op <= ld_b;
            3: ex_mem_op <= ld_hu;
            default: ex_mem_op <= ld_bu;
        endcase
        r = $random(seed);
        ex_gr_we        <= r[0];
        ex_res_from_mem <= r[1];
        ex_addr_low2    <= r[3:2];
        ex_csr_we       <= r[4];
        ex_csr_re       <= r[5];
        ex_ertn         <= (r[10:8] == 3'd0);     // rare
        ex_syscall      <= (r[13:11] == 3'd0);
        ex_dest         <= r[20:16];
        ex_csr_num      <= r[31:18];
        ex_pc           <= $random(seed);
        ex_inst         <= $random(seed);
        ex_alu_result   <= $random(seed);
        ex_csr_wmask    <= $random(seed);
        ex_csr_wvalue   <= $random(seed);
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        word_t w;
        if (took_new) begin
            w = $random(seed);
            p_sram = w;
            data_sram_rdata <= w;                 // held with the instruction
            new_offer();
            took_new = 1'b0;
        end
        r = $random(seed);
        ex_valid   <= (accepted < NUM_INSTR) && (r[1:0] != 2'b00);
        wb_allowin <= (r[3:2] != 2'b00);
        wb_ex      <= (r[9:4] == 6'd0);
        ertn_flush <= (r[15:10] == 6'd0);
    endtask

    task automatic check_outputs();
        logic flush;
        word_t exp_res;
        flush = wb_ex | ertn_flush;
        check_bit("mem_allowin", mem_allowin, !pend || (!flush && wb_allowin));
        check_bit("mem_wb_valid", mem_wb_valid, pend && !flush);
        check_bit("fwd_valid", fwd_valid, pend && p_gr_we);
        check_bit("mem_ex", mem_ex, pend && (p_ertn || p_syscall));
        if (pend) begin
            exp_res = p_res_from_mem ? expected_load(p_op, p_a, p_sram) : p_alu;
            check_word("wb_result", wb_result, exp_res);
            check_word("fwd_result", fwd_result, exp_res);
            check_word("wb_pc", wb_pc, p_pc);
            check_word("wb_inst", wb_inst, p_inst);
            check_word("wb_csr_wmask", wb_csr_wmask, p_csr_wmask);
            check_word("wb_csr_wvalue", wb_csr_wvalue, p_csr_wvalue);
            check_idx("wb_dest", wb_dest, p_dest);
            check_idx("fwd_dest", fwd_dest, p_dest);
            check_csr("wb_csr_num", wb_csr_num, p_csr_num);
            check_csr("fwd_csr_num", fwd_csr_num, p_csr_num);
            check_bit("wb_gr_we", wb_gr_we, p_gr_we);
            check_bit("wb_csr_we", wb_csr_we, p_csr_we);
            check_bit("wb_csr_re", wb_csr_re, p_csr_re);
            check_bit("wb_ertn", wb_ertn, p_ertn);
            check_bit("wb_syscall", wb_syscall, p_syscall);
            check_bit("fwd_is_csr", fwd_is_csr, p_csr_re || p_csr_we);
        end
    endtask

    // what the coming edge does to the stage
    task automatic advance_model();
        logic flush;
        logic accept;
        flush  = wb_ex | ertn_flush;
        accept = ex_valid && mem_allowin;
        if (flush) begin
            if (pend) begin
                dropped++;
            end
            if (accept) begin
                dropped++;                        // taken into an empty stage, then cleared
            end
            pend = 1'b0;
        end else begin
            if (pend && wb_allowin) begin
                retired++;
                pend = 1'b0;
            end
            if (accept) begin
                pend           = 1'b1;
                p_gr_we        = ex_gr_we;
                p_res_from_mem = ex_res_from_mem;
                p_op           = ex_mem_op;
                p_a            = ex_addr_low2;
                p_dest         = ex_dest;
                p_pc           = ex_pc;
                p_inst         = ex_inst;
                p_alu          = ex_alu_result;
                p_csr_we       = ex_csr_we;
                p_csr_re       = ex_csr_re;
                p_csr_num      = ex_csr_num;
                p_csr_wmask    = ex_csr_wmask;
                p_csr_wvalue   = ex_csr_wvalue;
                p_ertn         = ex_ertn;
                p_syscall      = ex_syscall;
            end
        end
        if (accept) begin
            accepted++;
            took_new = 1'b1;
        end
    endtask

    initial begin
        seed     = 29449;
        accepted = 0;
        retired  = 0;
        dropped  = 0;
        pend     = 1'b0;
        took_new = 1'b0;
        resetn          <= 1'b0;
        ex_valid        <= 1'b0;
        wb_allowin      <= 1'b0;
        wb_ex           <= 1'b0;
        ertn_flush      <= 1'b0;
        data_sram_rdata <= '0;
        new_offer();
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check_bit("mem_allowin", mem_allowin, 1'b1);
        check_bit("mem_wb_valid", mem_wb_valid, 1'b0);
        check_bit("mem_ex", mem_ex, 1'b0);
        check_bit("fwd_valid", fwd_valid, 1'b0);
        while (accepted < NUM_INSTR || pend) begin
            @(posedge clk);
            drive_inputs();
            @(negedge clk);
            check_outputs();
            advance_model();
        end
        $display("%0d retired, %0d flushed", retired, dropped);
        $display(">>> PASS");
        $finish;
    end

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ns

module mem_stage
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    input  logic        ex_valid,
    input  logic        ex_gr_we,
    input  logic        ex_res_from_mem,
    input  mem_op_e     ex_mem_op,
    input  logic [1:0]  ex_addr_low2,
    input  reg_idx_t    ex_dest,
    input  word_t       ex_pc,
    input  word_t       ex_inst,
    input  word_t       ex_alu_result,
    input  logic        ex_csr_we,
    input  logic        ex_csr_re,
    input  csr_num_t    ex_csr_num,
    input  word_t       ex_csr_wmask,
    input  word_t       ex_csr_wvalue,
    input  logic        ex_ertn,
    input  logic        ex_syscall,

    input  logic        wb_allowin,
    input  logic        wb_ex,
    input  logic        ertn_flush,
    input  word_t       data_sram_rdata,

    output logic        mem_allowin,
    output logic        mem_wb_valid,

    output logic        wb_gr_we,
    output word_t       wb_pc,
    output word_t       wb_inst,
    output word_t       wb_result,
    output reg_idx_t    wb_dest,
    output logic        wb_csr_we,
    output logic        wb_csr_re,
    output csr_num_t    wb_csr_num,
    output word_t       wb_csr_wmask,
    output word_t       wb_csr_wvalue,
    output logic        wb_ertn,
    output logic        wb_syscall,

    output logic        fwd_valid,
    output reg_idx_t    fwd_dest,
    output word_t       fwd_result,
    output logic        fwd_is_csr,
    output csr_num_t    fwd_csr_num,

    output logic        mem_ex
);

    logic       mem_valid;
    logic       gr_we;
    logic       res_from_mem;
    mem_op_e    mem_op;
    logic [1:0] addr_low2;
    reg_idx_t   dest;
    word_t      pc;
    word_t      inst;
    word_t      alu_result;
    logic       csr_we;
    logic       csr_re;
    csr_num_t   csr_num;
    word_t      csr_wmask;
    word_t      csr_wvalue;
    logic       ertn;
    logic       syscall;
    word_t      load_data;

    mem_stage_reg reg0 (
        .clk(clk), .resetn(resetn), .ex_valid(ex_valid), .wb_allowin(wb_allowin),
        .wb_ex(wb_ex), .ertn_flush(ertn_flush),
        .ex_gr_we(ex_gr_we), .ex_res_from_mem(ex_res_from_mem), .ex_mem_op(ex_mem_op),
        .ex_addr_low2(ex_addr_low2), .ex_dest(ex_dest), .ex_pc(ex_pc), .ex_inst(ex_inst),
        .ex_alu_result(ex_alu_result), .ex_csr_we(ex_csr_we), .ex_csr_re(ex_csr_re),
        .ex_csr_num(ex_csr_num), .ex_csr_wmask(ex_csr_wmask),
        .ex_csr_wvalue(ex_csr_wvalue), .ex_ertn(ex_ertn), .ex_syscall(ex_syscall),
        .mem_allowin(mem_allowin), .mem_wb_valid(mem_wb_valid), .mem_valid(mem_valid),
        .gr_we(gr_we), .res_from_mem(res_from_mem), .mem_op(mem_op),
        .addr_low2(addr_low2), .dest(dest), .pc(pc), .inst(inst),
        .alu_result(alu_result), .csr_we(csr_we), .csr_re(csr_re), .csr_num(csr_num),
        .csr_wmask(csr_wmask), .csr_wvalue(csr_wvalue), .ertn(ertn), .syscall(syscall)
    );

    // sram word belongs to the held instruction
    load_aligner align0 (
        .rdata(data_sram_rdata), .mem_op(mem_op), .addr_low2(addr_low2),
        .load_data(load_data)
    );

    mem_result_merge merge0 (
        .mem_valid(mem_valid), .gr_we(gr_we), .res_from_mem(res_from_mem), .dest(dest),
        .pc(pc), .inst(inst), .alu_result(alu_result), .load_data(load_data),
        .csr_we(csr_we), .csr_re(csr_re), .csr_num(csr_num), .csr_wmask(csr_wmask),
        .csr_wvalue(csr_wvalue), .ertn(ertn), .syscall(syscall),
        .wb_gr_we(wb_gr_we), .wb_pc(wb_pc), .wb_inst(wb_inst), .wb_result(wb_result),
        .wb_dest(wb_dest), .wb_csr_we(wb_csr_we), .wb_csr_re(wb_csr_re),
        .wb_csr_num(wb_csr_num), .wb_csr_wmask(wb_csr_wmask),
        .wb_csr_wvalue(wb_csr_wvalue), .wb_ertn(wb_ertn), .wb_syscall(wb_syscall),
        .fwd_valid(fwd_valid), .fwd_dest(fwd_dest), .fwd_result(fwd_result),
        .fwd_is_csr(fwd_is_csr), .fwd_csr_num(fwd_csr_num), .mem_ex(mem_ex)
    );

endmodule

// ==== verilog/mem_result_merge.sv ====
`timescale 1ns/1ns

module mem_result_merge
    import mem_pkg::*;
(
    input  logic        mem_valid,
    input  logic        gr_we,
    input  logic        res_from_mem,
    input  reg_idx_t    dest,
    input  word_t       pc,
    input  word_t       inst,
    input  word_t       alu_result,
    input  word_t       load_data,
    input  logic        csr_we,
    input  logic        csr_re,
    input  csr_num_t    csr_num,
    input  word_t       csr_wmask,
    input  word_t       csr_wvalue,
    input  logic        ertn,
    input  logic        syscall,

    output logic        wb_gr_we,
    output word_t       wb_pc,
    output word_t       wb_inst,
    output word_t       wb_result,
    output reg_idx_t    wb_dest,
    output logic        wb_csr_we,
    output logic        wb_csr_re,
    output csr_num_t    wb_csr_num,
    output word_t       wb_csr_wmask,
    output word_t       wb_csr_wvalue,
    output logic        wb_ertn,
    output logic        wb_syscall,

    output logic        fwd_valid,
    output reg_idx_t    fwd_dest,
    output word_t       fwd_result,
    output logic        fwd_is_csr,
    output csr_num_t    fwd_csr_num,

    output logic        mem_ex
);

    word_t final_result;

    assign final_result = res_from_mem ? load_data : alu_result;

    assign wb_gr_we      = gr_we;
    assign wb_pc         = pc;
    assign wb_inst       = inst;
    assign wb_result     = final_result;
    assign wb_dest       = dest;
    assign wb_csr_we     = csr_we;
    assign wb_csr_re     = csr_re;
    assign wb_csr_num    = csr_num;
    assign wb_csr_wmask  = csr_wmask;
    assign wb_csr_wvalue = csr_wvalue;
    assign wb_ertn       = ertn;
    assign wb_syscall    = syscall;

    // bypass back to decode
    assign fwd_valid   = mem_valid & gr_we;
    assign fwd_dest    = dest;
    assign fwd_result  = final_result;
    assign fwd_is_csr  = csr_re | csr_we;   // decode stalls on csr hazards
    assign fwd_csr_num = csr_num;

    assign mem_ex = mem_valid & (syscall | ertn);

endmodule

// ==== verilog/load_aligner.sv ====
`timescale 1ns/1ns

module load_aligner
    import mem_pkg::*;
(
    input  word_t       rdata,
    input  mem_op_e     mem_op,
    input  logic [1:0]  addr_low2,
    output word_t       load_data
);

    localparam int HALF_PAD = $bits(word_t) - 16;
    localparam int BYTE_PAD = $bits(word_t) - 8;

    logic [15:0] half_sel;
    logic [7:0]  byte_sel;
    logic        op_unsigned;
    logic [1:0]  op_size;

    assign op_unsigned = mem_op[2];
    assign op_size     = mem_op[1:0];

    assign half_sel = addr_low2[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (addr_low2)
            2'b00:   byte_sel = rdata[7:0];
            2'b01:   byte_sel = rdata[15:8];
            2'b10:   byte_sel = rdata[23:16];
            default: byte_sel = rdata[31:24];
        endcase
    end

    always_comb begin
        case (op_size)
            2'b01: begin
                load_data = op_unsigned ? {{HALF_PAD{1'b0}}, half_sel}
                                        : {{HALF_PAD{half_sel[15]}}, half_sel};
            end
            2'b10: begin
                load_data = op_unsigned ? {{BYTE_PAD{1'b0}}, byte_sel}
                                        : {{BYTE_PAD{byte_sel[7]}}, byte_sel};
            end
            default: begin
                load_data = rdata;        // whole word for ld_w
            end
        endcase
    end

endmodule

// ==== verilog/mem_stage_reg.sv ====
`timescale 1ns/1ns

module mem_stage_reg
    import mem_pkg::*;
(
    input  logic        clk,
    input  logic        resetn,

    input  logic        ex_valid,
    input  logic        wb_allowin,
    input  logic        wb_ex,
    input  logic        ertn_flush,

    input  logic        ex_gr_we,
    input  logic        ex_res_from_mem,
    input  mem_op_e     ex_mem_op,
    input  logic [1:0]  ex_addr_low2,
    input  reg_idx_t    ex_dest,
    input  word_t       ex_pc,
    input  word_t       ex_inst,
    input  word_t       ex_alu_result,
    input  logic        ex_csr_we,
    input  logic        ex_csr_re,
    input  csr_num_t    ex_csr_num,
    input  word_t       ex_csr_wmask,
    input  word_t       ex_csr_wvalue,
    input  logic        ex_ertn,
    input  logic        ex_syscall,

    output logic        mem_allowin,
    output logic        mem_wb_valid,
    output logic        mem_valid,

    output logic        gr_we,
    output logic        res_from_mem,
    output mem_op_e     mem_op,
    output logic [1:0]  addr_low2,
    output reg_idx_t    dest,
    output word_t       pc,
    output word_t       inst,
    output word_t       alu_result,
    output logic        csr_we,
    output logic        csr_re,
    output csr_num_t    csr_num,
    output word_t       csr_wmask,
    output word_t       csr_wvalue,
    output logic        ertn,
    output logic        syscall
);

    logic flush;
    logic accept;

    assign flush = wb_ex | ertn_flush;
    assign accept = ex_valid & mem_allowin;

    // stage always ready, so only the flush holds the instruction back
    assign mem_wb_valid = mem_valid & ~flush;
    assign mem_allowin = ~mem_valid | (mem_wb_valid & wb_allowin);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            mem_valid <= 1'b0;            // drop held instruction
        end else if (mem_allowin) begin
            mem_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            gr_we        <= ex_gr_we;
            res_from_mem <= ex_res_from_mem;
            mem_op       <= ex_mem_op;
            addr_low2    <= ex_addr_low2;
            dest         <= ex_dest;
            pc           <= ex_pc;
            inst         <= ex_inst;
            alu_result   <= ex_alu_result;
            csr_we       <= ex_csr_we;
            csr_re       <= ex_csr_re;
            csr_num      <= ex_csr_num;
            csr_wmask    <= ex_csr_wmask;
            csr_wvalue   <= ex_csr_wvalue;
            ertn         <= ex_ertn;
            syscall      <= ex_syscall;
        end
    end

endmodule

// ==== verilog/mem_pkg.sv ====
package mem_pkg;

`include "mem_config.svh"

    typedef logic [`MEM_XLEN-1:0] word_t;

    typedef logic [`MEM_REG_IDX_W-1:0] reg_idx_t;

    typedef logic [`MEM_CSR_NUM_W-1:0] csr_num_t;

    // bit 2 marks unsigned, bits 1:0 give word/half/byte
    typedef enum logic [2:0] {
        ld_w  = 3'b000,
        ld_h  = 3'b001,
        ld_b  = 3'b010,
        ld_hu = 3'b101,
        ld_bu = 3'b110
    } mem_op_e;

endpackage

// ==== include/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// data word width
`define MEM_XLEN 32

// destination register index width
`define MEM_REG_IDX_W 5

// csr number width
`define MEM_CSR_NUM_W 14

`endif
